//--- project.f
hw/lsu_isa_pkg.sv
hw/lsu_bus_pkg.sv
hw/lsu_id.sv
hw/lsu_op_queue.sv
hw/lsu_data_align.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
verification/lsu_wb_mem.sv
verification/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module lsu_tb \
		-f project.f --Mdir $(OBJ_DIR) -o lsu_sim

run: compile
	./$(OBJ_DIR)/lsu_sim | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/lsu_tb.sv
/* Testbench for lsu_top. Addresses alias into a 256-byte memory model and every
   op in the table is naturally aligned. */

`timescale 1ns/1ps

module lsu_tb;

    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    localparam int          MEM_WORDS  = 64;
    localparam int unsigned SEED       = 32'h5aed_67ca;
    localparam int          RST_CYCLES = 10;
    localparam int          DRIVE_DLY  = 1;

    // One reservation-station op; hold is idle cycles after acceptance
    typedef struct {
        lsu_opcode_t opcode;
        logic [2:0]  funct3;
        int          imm;
        lsu_addr_t   base;
        lsu_data_t   sdata;
        lsu_tag_t    tag;
        int          hold;
    } stim_row_t;

    logic        clk;
    logic        rst_n;
    logic        valid;
    lsu_opcode_t opcode;
    lsu_data_t   insn;
    lsu_addr_t   src_a;
    lsu_data_t   src_b;
    lsu_tag_t    tag;
    logic        ready;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_adr_t     wb_adr;
    wb_sel_t     wb_sel;
    lsu_data_t   wb_dat_w;
    logic        wb_ack;
    lsu_data_t   wb_dat_r;
    logic        rslt_valid;
    lsu_tag_t    rslt_tag;
    lsu_data_t   rslt_data;
    logic        rslt_is_store;

    stim_row_t  rows[$];
    logic [7:0] ref_mem [256];
    wb_adr_t    exp_adr_q[$];
    wb_sel_t    exp_sel_q[$];
    logic       exp_we_q[$];
    lsu_data_t  exp_wdat_q[$];
    lsu_data_t  exp_mask_q[$];
    lsu_tag_t   exp_tag_q[$];
    lsu_data_t  exp_data_q[$];
    logic       exp_store_q[$];

    int   cycle_cnt = 0;
    int   cycle_limit;
    logic checking;
    logic rslt_seen_last;
    logic ready_fell;

    lsu_top dut (
        .clk             (clk),
        .i_rst_n         (rst_n),
        .i_valid         (valid),
        .i_opcode        (opcode),
        .i_insn          (insn),
        .i_src_a         (src_a),
        .i_src_b         (src_b),
        .i_tag           (tag),
        .o_ready         (ready),
        .o_wb_cyc        (wb_cyc),
        .o_wb_stb        (wb_stb),
        .o_wb_we         (wb_we),
        .o_wb_adr        (wb_adr),
        .o_wb_sel        (wb_sel),
        .o_wb_dat        (wb_dat_w),
        .i_wb_ack        (wb_ack),
        .i_wb_dat        (wb_dat_r),
        .o_rslt_valid    (rslt_valid),
        .o_rslt_tag      (rslt_tag),
        .o_rslt_data     (rslt_data),
        .o_rslt_is_store (rslt_is_store)
    );

    lsu_wb_mem #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (SEED)
    ) mem_model (
        .clk   (clk),
        .i_cyc (wb_cyc),
        .i_stb (wb_stb),
        .i_we  (wb_we),
        .i_adr (wb_adr),
        .i_sel (wb_sel),
        .i_dat (wb_dat_w),
        .o_ack (wb_ack),
        .o_dat (wb_dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_tag(input lsu_tag_t got, input lsu_tag_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_data(input lsu_data_t got, input lsu_data_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_wb(input wb_adr_t got_adr, input wb_sel_t got_sel,
                            input wb_adr_t exp_adr, input wb_sel_t exp_sel);
        if (got_adr !== exp_adr || got_sel !== exp_sel) begin
            stop_on_error($sformatf("Mismatch at %0t: o_wb_adr/o_wb_sel got %h/%b expected %h/%b",
                                    $time, got_adr, got_sel, exp_adr, exp_sel));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                    $time, what, got, exp));
        end
    endtask

    function automatic void add_row(input lsu_opcode_t op, input logic [2:0] f3, input int imm,
                                    input lsu_addr_t base, input lsu_data_t sdata,
                                    input lsu_tag_t row_tag, input int hold);
        stim_row_t r;
        r = '{op, f3, imm, base, sdata, row_tag, hold};
        rows.push_back(r);
    endfunction

    task automatic build_table();
        // Loads at every offset, word 0 holds bytes 21 43 80 80
        add_row(OPCODE_LOAD,  3'd0,     0, 32'h0000_0000, 32'h0000_0000, 6'd1,  2);
        add_row(OPCODE_LOAD,  3'd0,     3, 32'h0000_0000, 32'h0000_0000, 6'd2,  1);
        add_row(OPCODE_LOAD,  3'd4,     2, 32'h0000_0000, 32'h0000_0000, 6'd3,  0);
        add_row(OPCODE_LOAD,  3'd4,     1, 32'h0000_0000, 32'h0000_0000, 6'd4,  3);
        add_row(OPCODE_LOAD,  3'd0,     5, 32'h0000_0000, 32'h0000_0000, 6'd5,  1);
        add_row(OPCODE_LOAD,  3'd0,     6, 32'h0000_0000, 32'h0000_0000, 6'd6,  2);
        add_row(OPCODE_LOAD,  3'd1,     0, 32'h0000_0000, 32'h0000_0000, 6'd7,  0);
        add_row(OPCODE_LOAD,  3'd1,     2, 32'h0000_0000, 32'h0000_0000, 6'd8,  1);
        add_row(OPCODE_LOAD,  3'd5,     2, 32'h0000_0000, 32'h0000_0000, 6'd9,  2);
        add_row(OPCODE_LOAD,  3'd5,     4, 32'h0000_0000, 32'h0000_0000, 6'd10, 0);
        add_row(OPCODE_LOAD,  3'd2,     4, 32'h0000_0000, 32'h0000_0000, 6'd11, 3);
        // Negative and extreme immediates
        add_row(OPCODE_LOAD,  3'd2,    -8, 32'h0000_0040, 32'h0000_0000, 6'd12, 1);
        add_row(OPCODE_LOAD,  3'd0,    -1, 32'h0000_0020, 32'h0000_0000, 6'd13, 0);
        add_row(OPCODE_LOAD,  3'd2, -2048, 32'h0000_0820, 32'h0000_0000, 6'd14, 2);
        add_row(OPCODE_LOAD,  3'd5,  2046, 32'h0000_0100, 32'h0000_0000, 6'd15, 1);
        // Stores at every offset, then read back the merged word
        add_row(OPCODE_STORE, 3'd0,     0, 32'h0000_0060, 32'h1234_56f1, 6'd16, 1);
        add_row(OPCODE_STORE, 3'd0,     1, 32'h0000_0060, 32'hffff_ff82, 6'd17, 0);
        add_row(OPCODE_STORE, 3'd0,    -2, 32'h0000_0064, 32'h0000_0003, 6'd18, 2);
        add_row(OPCODE_STORE, 3'd0,  2047, 32'hffff_f864, 32'h0000_00c4, 6'd19, 1);
        add_row(OPCODE_LOAD,  3'd2,     0, 32'h0000_0060, 32'h0000_0000, 6'd20, 1);
        add_row(OPCODE_STORE, 3'd1,     8, 32'h0000_0060, 32'h0000_beef, 6'd21, 0);
        add_row(OPCODE_STORE, 3'd1,    -6, 32'h0000_0070, 32'h5555_1357, 6'd22, 1);
        add_row(OPCODE_LOAD,  3'd2,     8, 32'h0000_0060, 32'h0000_0000, 6'd23, 2);
        add_row(OPCODE_LOAD,  3'd1,     8, 32'h0000_0060, 32'h0000_0000, 6'd24, 0);
        add_row(OPCODE_STORE, 3'd2,    -4, 32'h0000_0074, 32'hdead_beef, 6'd25, 1);
        add_row(OPCODE_STORE, 3'd0, -2047, 32'h0000_0870, 32'h0000_005a, 6'd26, 0);
        add_row(OPCODE_LOAD,  3'd2,     0, 32'h0000_0070, 32'h0000_0000, 6'd27, 3);
        // Back-to-back burst, slow acks fill the queue
        add_row(OPCODE_STORE, 3'd2,     0, 32'h0000_0080, 32'ha5a5_0f0f, 6'd28, 0);
        add_row(OPCODE_LOAD,  3'd2,     0, 32'h0000_0080, 32'h0000_0000, 6'd29, 0);
        add_row(OPCODE_STORE, 3'd0,     5, 32'h0000_0080, 32'h0000_009c, 6'd30, 0);
        add_row(OPCODE_LOAD,  3'd4,     5, 32'h0000_0080, 32'h0000_0000, 6'd31, 0);
        add_row(OPCODE_STORE, 3'd1,    10, 32'h0000_0080, 32'h0000_f00d, 6'd32, 0);
        add_row(OPCODE_LOAD,  3'd1,    10, 32'h0000_0080, 32'h0000_0000, 6'd33, 0);
        add_row(OPCODE_LOAD,  3'd2,     4, 32'h0000_0080, 32'h0000_0000, 6'd34, 0);
        add_row(OPCODE_LOAD,  3'd0,    11, 32'h0000_0080, 32'h0000_0000, 6'd35, 0);
        add_row(OPCODE_LOAD,  3'd5,     8, 32'h0000_0080, 32'h0000_0000, 6'd36, 0);
        add_row(OPCODE_STORE, 3'd2,    12, 32'h0000_0080, 32'h0bad_cafe, 6'd37, 0);
        add_row(OPCODE_LOAD,  3'd2,    12, 32'h0000_0080, 32'h0000_0000, 6'd38, 0);
        add_row(OPCODE_LOAD,  3'd0,     0, 32'h0000_0000, 32'h0000_0000, 6'd39, 0);
    endtask

    // Expected bus cycle and result, from RV32 load/store rules
    task automatic predict_op(input stim_row_t r);
        lsu_addr_t ea;
        lsu_addr_t a;
        lsu_data_t val;
        lsu_data_t mask;
        int        n;
        int        off;
        logic      is_store;
        ea       = r.base + lsu_addr_t'(r.imm);
        is_store = (r.opcode == OPCODE_STORE);
        n        = (r.funct3[1:0] == 2'd0) ? 1 : ((r.funct3[1:0] == 2'd1) ? 2 : 4);
        off      = int'(ea[1:0]);
        mask     = lsu_data_t'(((64'h1 << (8 * n)) - 64'h1) << (8 * off));
        val      = '0;
        for (int b = 0; b < n; b++) begin
            a = ea + lsu_addr_t'(b);
            if (is_store) begin
                ref_mem[a[7:0]] = 8'(r.sdata >> (8 * b));
            end else begin
                val = val | (lsu_data_t'(ref_mem[a[7:0]]) << (8 * b));
            end
        end
        // funct3 bit 2 marks the unsigned loads
        if (!r.funct3[2] && n == 1) begin
            val = {{24{val[7]}}, val[7:0]};
        end else if (!r.funct3[2] && n == 2) begin
            val = {{16{val[15]}}, val[15:0]};
        end
        exp_adr_q.push_back(ea[31:2]);
        exp_sel_q.push_back(wb_sel_t'(((1 << n) - 1) << off));
        exp_we_q.push_back(is_store);
        exp_wdat_q.push_back(lsu_data_t'(r.sdata << (8 * off)) & mask);
        exp_mask_q.push_back(mask);
        exp_tag_q.push_back(r.tag);
        exp_data_q.push_back(val);
        exp_store_q.push_back(is_store);
    endtask

    task automatic drive_op(input stim_row_t r);
        logic [11:0] imm12;
        logic        accepted;
        imm12 = r.imm[11:0];
        predict_op(r);
        opcode = r.opcode;
        if (r.opcode == OPCODE_STORE) begin
            insn = {imm12[11:5], 5'd2, 5'd1, r.funct3, imm12[4:0], r.opcode};
        end else begin
            insn = {imm12, 5'd1, r.funct3, 5'd5, r.opcode};
        end
        src_a    = r.base;
        src_b    = r.sdata;
        tag      = r.tag;
        valid    = 1'b1;
        accepted = 1'b0;
        // o_ready is steady mid-cycle, the transfer happens on the next edge
        while (!accepted) begin
            @(negedge clk);
            accepted = ready;
            @(posedge clk);
        end
        #DRIVE_DLY;
        valid = 1'b0;
        if (r.hold > 0) begin
            repeat (r.hold) @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic check_bus_cycle();
        lsu_data_t mask;
        lsu_data_t wdat;
        if (exp_adr_q.size() == 0) begin
            stop_on_error("Bus cycle acknowledged with no op outstanding");
        end else begin
            mask = exp_mask_q.pop_front();
            wdat = exp_wdat_q.pop_front();
            check_wb(wb_adr, wb_sel, exp_adr_q.pop_front(), exp_sel_q.pop_front());
            check_flag(wb_we, exp_we_q.pop_front(), "o_wb_we");
            if (wb_we) begin
                check_data(wb_dat_w & mask, wdat, "o_wb_dat store lanes");
            end
        end
    endtask

    task automatic check_result();
        logic      is_store;
        lsu_data_t data;
        if (exp_tag_q.size() == 0) begin
            stop_on_error("Result returned with no op outstanding");
        end else begin
            is_store = exp_store_q.pop_front();
            data     = exp_data_q.pop_front();
            check_flag(rslt_seen_last, 1'b0, "o_rslt_valid in the previous cycle");
            check_tag(rslt_tag, exp_tag_q.pop_front(), "o_rslt_tag");
            check_flag(rslt_is_store, is_store, "o_rslt_is_store");
            if (!is_store) begin
                check_data(rslt_data, data, "o_rslt_data");
            end
        end
    endtask

    // Bus and result monitor samples mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            if (wb_cyc && wb_stb && wb_ack) begin
                check_bus_cycle();
            end
            if (rslt_valid) begin
                check_result();
            end
            if (!ready) begin
                ready_fell = 1'b1;
            end
            rslt_seen_last = rslt_valid;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d cycles with %0d results outstanding",
                                    cycle_cnt, exp_tag_q.size()));
        end
    end

    initial begin
        rst_n          = 1'b0;
        valid          = 1'b0;
        opcode         = '0;
        insn           = '0;
        src_a          = '0;
        src_b          = '0;
        tag            = '0;
        checking       = 1'b0;
        rslt_seen_last = 1'b0;
        ready_fell     = 1'b0;
        build_table();
        cycle_limit = rows.size() * 12 + 100;

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        @(negedge clk);
        check_flag(wb_cyc, 1'b0, "o_wb_cyc after reset");
        check_flag(wb_stb, 1'b0, "o_wb_stb after reset");
        check_flag(rslt_valid, 1'b0, "o_rslt_valid after reset");
        check_flag(ready, 1'b1, "o_ready after reset");

        // Reference memory starts from the model's preload
        for (int i = 0; i < MEM_WORDS; i++) begin
            for (int b = 0; b < 4; b++) begin
                ref_mem[i * 4 + b] = 8'(mem_model.mem[i] >> (8 * b));
            end
        end
        checking = 1'b1;

        @(posedge clk);
        #DRIVE_DLY;
        foreach (rows[i]) begin
            drive_op(rows[i]);
        end
        while (exp_tag_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if (exp_adr_q.size() != 0) begin
            stop_on_error("Bus cycles still expected after all results returned");
        end else if (!ready_fell) begin
            stop_on_error("o_ready never fell during the back-to-back burst");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- verification/lsu_wb_mem.sv
/* Wishbone classic slave memory for simulation. Word address wraps at MEM_WORDS,
   ack follows stb after 0 to 3 random cycles and lasts one cycle. */

`timescale 1ns/1ps

module lsu_wb_mem #(
    parameter int          MEM_WORDS = 64,
    parameter int unsigned SEED      = 32'h0
) (
    input  logic                   clk,
    input  logic                   i_cyc,
    input  logic                   i_stb,
    input  logic                   i_we,
    input  lsu_bus_pkg::wb_adr_t   i_adr,
    input  lsu_bus_pkg::wb_sel_t   i_sel,
    input  lsu_isa_pkg::lsu_data_t i_dat,
    output logic                   o_ack,
    output lsu_isa_pkg::lsu_data_t o_dat
);

    import lsu_isa_pkg::*;

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    lsu_data_t           mem [MEM_WORDS];
    lsu_data_t           lane_mask;
    logic [IDX_BITS-1:0] idx;
    int                  wait_left;
    logic                armed;

    assign idx       = i_adr[IDX_BITS-1:0];
    assign lane_mask = {{8{i_sel[3]}}, {8{i_sel[2]}}, {8{i_sel[1]}}, {8{i_sel[0]}}};

    // Preload pattern mixes every word index bit into all four bytes
    function automatic lsu_data_t fill_word(input int word_idx);
        return lsu_data_t'(word_idx) * 32'h9e37_79b1 + 32'h8080_4321;
    endfunction

    initial begin
        void'($urandom(SEED));
        armed     = 1'b0;
        wait_left = 0;
        o_ack    <= 1'b0;
        o_dat    <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= fill_word(i);
        end
        forever begin
            @(posedge clk);
            if (o_ack) begin
                o_ack <= 1'b0;
                armed  = 1'b0;
            end else if (i_cyc && i_stb) begin
                // New cycle draws its own ack delay
                if (!armed) begin
                    wait_left = $urandom_range(3, 0);
                    armed     = 1'b1;
                end
                if (wait_left == 0) begin
                    o_ack <= 1'b1;
                    o_dat <= mem[idx];
                    if (i_we) begin
                        mem[idx] <= (mem[idx] & ~lane_mask) | (i_dat & lane_mask);
                    end
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

//--- hw/lsu_top.sv
/* Load/store unit top. Ops are accepted while o_ready is high and complete in
   acceptance order, one Wishbone classic cycle each. */

`timescale 1ns/1ps

module lsu_top (
    input  logic                     clk,
    input  logic                     i_rst_n,

    // Reservation station
    input  logic                     i_valid,
    input  lsu_isa_pkg::lsu_opcode_t i_opcode,
    input  lsu_isa_pkg::lsu_data_t   i_insn,
    input  lsu_isa_pkg::lsu_addr_t   i_src_a,
    input  lsu_isa_pkg::lsu_data_t   i_src_b,
    input  lsu_isa_pkg::lsu_tag_t    i_tag,
    output logic                     o_ready,

    // Wishbone master
    output logic                     o_wb_cyc,
    output logic                     o_wb_stb,
    output logic                     o_wb_we,
    output lsu_bus_pkg::wb_adr_t     o_wb_adr,
    output lsu_bus_pkg::wb_sel_t     o_wb_sel,
    output lsu_isa_pkg::lsu_data_t   o_wb_dat,
    input  logic                     i_wb_ack,
    input  lsu_isa_pkg::lsu_data_t   i_wb_dat,

    // Result
    output logic                     o_rslt_valid,
    output lsu_isa_pkg::lsu_tag_t    o_rslt_tag,
    output lsu_isa_pkg::lsu_data_t   o_rslt_data,
    output logic                     o_rslt_is_store
);

    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    // Decoder to queue
    lsu_func_t id_func;
    lsu_addr_t id_addr;
    lsu_data_t id_data;
    lsu_tag_t  id_tag;
    logic      push;

    // Queue head
    lsu_func_t q_func;
    lsu_addr_t q_addr;
    lsu_data_t q_data;
    lsu_tag_t  q_tag;
    logic      q_empty;
    logic      q_full;
    logic      pop;

    // Aligner outputs
    wb_sel_t   al_sel;
    lsu_data_t al_wr_data;
    lsu_data_t al_ld_data;

    assign o_ready = !q_full;
    assign push    = i_valid && !q_full;

    lsu_id u_id (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_opcode (i_opcode),
        .i_insn   (i_insn),
        .i_src_a  (i_src_a),
        .i_src_b  (i_src_b),
        .i_tag    (i_tag),
        .o_func   (id_func),
        .o_addr   (id_addr),
        .o_data   (id_data),
        .o_tag    (id_tag)
    );

    lsu_op_queue u_queue (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_push  (push),
        .i_pop   (pop),
        .i_func  (id_func),
        .i_addr  (id_addr),
        .i_data  (id_data),
        .i_tag   (id_tag),
        .o_func  (q_func),
        .o_addr  (q_addr),
        .o_data  (q_data),
        .o_tag   (q_tag),
        .o_empty (q_empty),
        .o_full  (q_full)
    );

    lsu_data_align u_align (
        .i_func    (q_func),
        .i_offset  (q_addr[1:0]),
        .i_st_data (q_data),
        .o_sel     (al_sel),
        .o_wr_data (al_wr_data),
        .i_rd_data (i_wb_dat),
        .o_ld_data (al_ld_data)
    );

    lsu_ctrl u_ctrl (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_empty         (q_empty),
        .i_func          (q_func),
        .i_addr          (q_addr),
        .i_tag           (q_tag),
        .i_sel           (al_sel),
        .i_wr_data       (al_wr_data),
        .i_ld_data       (al_ld_data),
        .o_pop           (pop),
        .o_wb_cyc        (o_wb_cyc),
        .o_wb_stb        (o_wb_stb),
        .o_wb_we         (o_wb_we),
        .o_wb_adr        (o_wb_adr),
        .o_wb_sel        (o_wb_sel),
        .o_wb_dat        (o_wb_dat),
        .i_wb_ack        (i_wb_ack),
        .o_rslt_valid    (o_rslt_valid),
        .o_rslt_tag      (o_rslt_tag),
        .o_rslt_data     (o_rslt_data),
        .o_rslt_is_store (o_rslt_is_store)
    );

endmodule

//--- hw/lsu_ctrl.sv
/* Runs one Wishbone classic cycle per queued op, head first. Results appear for
   one cycle after ack; o_rslt_data is valid only for loads. */

`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // Queue head and aligned data
    input  logic                   i_empty,
    input  lsu_isa_pkg::lsu_func_t i_func,
    input  lsu_isa_pkg::lsu_addr_t i_addr,
    input  lsu_isa_pkg::lsu_tag_t  i_tag,
    input  lsu_bus_pkg::wb_sel_t   i_sel,
    input  lsu_isa_pkg::lsu_data_t i_wr_data,
    input  lsu_isa_pkg::lsu_data_t i_ld_data,
    output logic                   o_pop,

    // Wishbone master
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic                   o_wb_we,
    output lsu_bus_pkg::wb_adr_t   o_wb_adr,
    output lsu_bus_pkg::wb_sel_t   o_wb_sel,
    output lsu_isa_pkg::lsu_data_t o_wb_dat,
    input  logic                   i_wb_ack,

    // Completion
    output logic                   o_rslt_valid,
    output lsu_isa_pkg::lsu_tag_t  o_rslt_tag,
    output lsu_isa_pkg::lsu_data_t o_rslt_data,
    output logic                   o_rslt_is_store
);

    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    lsu_state_t state;
    lsu_state_t state_next;
    logic       is_store;
    logic       misaligned;

    assign is_store = (i_func == LSU_FUNC_SB) || (i_func == LSU_FUNC_SH) ||
                      (i_func == LSU_FUNC_SW);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            ST_IDLE: state_next = i_empty ? ST_IDLE : ST_BUS;
            ST_BUS:  state_next = i_wb_ack ? ST_DONE : ST_BUS;
            default: state_next = ST_IDLE;
        endcase
    end

    // Bus signals come straight from the head, which holds until pop
    assign o_wb_cyc = (state == ST_BUS);
    assign o_wb_stb = (state == ST_BUS);
    assign o_wb_we  = o_wb_cyc && is_store;
    assign o_wb_adr = i_addr[ADDR_WIDTH-1:2];
    assign o_wb_sel = i_sel;
    assign o_wb_dat = i_wr_data;

    assign o_pop    = o_wb_cyc && i_wb_ack;

    // Capture result on the ack edge
    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_rslt_tag      <= i_tag;
            o_rslt_data     <= i_ld_data;
            o_rslt_is_store <= is_store;
        end
    end

    assign o_rslt_valid = (state == ST_DONE);

    always_comb begin
        case (i_func)
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: misaligned = i_addr[0];
            LSU_FUNC_LW, LSU_FUNC_SW:               misaligned = |i_addr[1:0];
            default:                                misaligned = 1'b0;
        endcase
    end

    // Every strobe belongs to an open cycle on a queued op
    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (!i_rst_n) o_wb_stb |-> o_wb_cyc && !i_empty
    ) else $error("lsu_ctrl: stb without cyc or without a queued op");

    // Queue head must not move under an open bus cycle
    a_adr_stable: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (o_wb_cyc && !i_wb_ack) |=> o_wb_cyc && $stable(o_wb_adr) && $stable(o_wb_sel)
    ) else $error("lsu_ctrl: address changed while waiting for ack");

    a_aligned: assert property (
        @(posedge clk) disable iff (!i_rst_n) o_wb_cyc |-> !misaligned
    ) else $error("lsu_ctrl: misaligned access on the bus");

endmodule

//--- hw/lsu_data_align.sv
/* Byte-lane steering between the 32-bit bus and the register file. Assumes the
   access is naturally aligned; misaligned offsets give undefined lanes. */

`timescale 1ns/1ps

module lsu_data_align (
    input  lsu_isa_pkg::lsu_func_t i_func,
    input  logic [1:0]             i_offset,

    // Store path
    input  lsu_isa_pkg::lsu_data_t i_st_data,
    output lsu_bus_pkg::wb_sel_t   o_sel,
    output lsu_isa_pkg::lsu_data_t o_wr_data,

    // Load path
    input  lsu_isa_pkg::lsu_data_t i_rd_data,
    output lsu_isa_pkg::lsu_data_t o_ld_data
);

    import lsu_isa_pkg::*;

    logic [4:0] lane_shift;
    lsu_data_t  rd_shifted;

    // Move the addressed lanes down to bit 0
    assign lane_shift = {i_offset, 3'b000};
    assign rd_shifted = i_rd_data >> lane_shift;

    // Lanes touched by the access, loads included
    always_comb begin
        case (i_func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: o_sel = 4'b0001 << i_offset;
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: o_sel = i_offset[1] ? 4'b1100 : 4'b0011;
            default:                                o_sel = 4'b1111;
        endcase
    end

    // Replicate narrow store data so every lane carries it
    always_comb begin
        case (i_func)
            LSU_FUNC_SB: o_wr_data = {4{i_st_data[7:0]}};
            LSU_FUNC_SH: o_wr_data = {2{i_st_data[15:0]}};
            default:     o_wr_data = i_st_data;
        endcase
    end

    // Extend the loaded value
    always_comb begin
        case (i_func)
            LSU_FUNC_LB:  o_ld_data = {{(DATA_WIDTH-8){rd_shifted[7]}}, rd_shifted[7:0]};
            LSU_FUNC_LBU: o_ld_data = {{(DATA_WIDTH-8){1'b0}}, rd_shifted[7:0]};
            LSU_FUNC_LH:  o_ld_data = {{(DATA_WIDTH-16){rd_shifted[15]}}, rd_shifted[15:0]};
            LSU_FUNC_LHU: o_ld_data = {{(DATA_WIDTH-16){1'b0}}, rd_shifted[15:0]};
            default:      o_ld_data = rd_shifted;
        endcase
    end

endmodule

//--- hw/lsu_op_queue.sv
/* In-order circular FIFO of decoded memory ops. The caller must not push when
   o_full is high nor pop when o_empty is high. */

`timescale 1ns/1ps

module lsu_op_queue (
    input  logic                   clk,
    input  logic                   i_rst_n,

    input  logic                   i_push,
    input  logic                   i_pop,

    // Entry written on push
    input  lsu_isa_pkg::lsu_func_t i_func,
    input  lsu_isa_pkg::lsu_addr_t i_addr,
    input  lsu_isa_pkg::lsu_data_t i_data,
    input  lsu_isa_pkg::lsu_tag_t  i_tag,

    // Head entry
    output lsu_isa_pkg::lsu_func_t o_func,
    output lsu_isa_pkg::lsu_addr_t o_addr,
    output lsu_isa_pkg::lsu_data_t o_data,
    output lsu_isa_pkg::lsu_tag_t  o_tag,
    output logic                   o_empty,
    output logic                   o_full
);

    import lsu_isa_pkg::*;

    lsu_func_t     func_mem [OP_QUEUE_DEPTH];
    lsu_addr_t     addr_mem [OP_QUEUE_DEPTH];
    lsu_data_t     data_mem [OP_QUEUE_DEPTH];
    lsu_tag_t      tag_mem  [OP_QUEUE_DEPTH];

    op_queue_ptr_t wr_ptr;
    op_queue_ptr_t rd_ptr;
    op_queue_cnt_t count;

    // Pointers, occupancy
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == op_queue_ptr_t'(OP_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == op_queue_ptr_t'(OP_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (i_push) begin
            func_mem[wr_ptr] <= i_func;
            addr_mem[wr_ptr] <= i_addr;
            data_mem[wr_ptr] <= i_data;
            tag_mem[wr_ptr]  <= i_tag;
        end
    end

    assign o_func  = func_mem[rd_ptr];
    assign o_addr  = addr_mem[rd_ptr];
    assign o_data  = data_mem[rd_ptr];
    assign o_tag   = tag_mem[rd_ptr];

    assign o_empty = (count == '0);
    assign o_full  = (count == op_queue_cnt_t'(OP_QUEUE_DEPTH));

    // Ready gating in the top and the FSM must keep these from happening
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!i_rst_n) o_full |-> !i_push
    ) else $error("lsu_op_queue: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!i_rst_n) o_empty |-> !i_pop
    ) else $error("lsu_op_queue: pop while empty");

endmodule

//--- hw/lsu_id.sv
/* Combinational decode and address generation. Ops with an opcode other than
   LOAD or STORE must never be presented with i_valid high. */

`timescale 1ns/1ps

module lsu_id (
    input  logic                     clk,
    input  logic                     i_rst_n,

    // From reservation station
    input  logic                     i_valid,
    input  lsu_isa_pkg::lsu_opcode_t i_opcode,
    input  lsu_isa_pkg::lsu_data_t   i_insn,
    input  lsu_isa_pkg::lsu_addr_t   i_src_a,
    input  lsu_isa_pkg::lsu_data_t   i_src_b,
    input  lsu_isa_pkg::lsu_tag_t    i_tag,

    // Decoded op towards the queue
    output lsu_isa_pkg::lsu_func_t   o_func,
    output lsu_isa_pkg::lsu_addr_t   o_addr,
    output lsu_isa_pkg::lsu_data_t   o_data,
    output lsu_isa_pkg::lsu_tag_t    o_tag
);

    import lsu_isa_pkg::*;

    lsu_data_t imm_i;
    lsu_data_t imm_s;
    logic      is_store;

    // Sign-extended I-type and S-type immediates
    assign imm_i = {{(DATA_WIDTH-12){i_insn[31]}}, i_insn[31:20]};
    assign imm_s = {{(DATA_WIDTH-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};

    assign is_store = (i_opcode == OPCODE_STORE);

    // Effective address
    assign o_addr = i_src_a + (is_store ? imm_s : imm_i);
    assign o_data = i_src_b;
    assign o_tag  = i_tag;

    // funct3 decode, unknown encodings fall back to word access
    always_comb begin
        case (i_opcode)
            OPCODE_STORE: begin
                case (i_insn[14:12])
                    3'b000:  o_func = LSU_FUNC_SB;
                    3'b001:  o_func = LSU_FUNC_SH;
                    default: o_func = LSU_FUNC_SW;
                endcase
            end
            OPCODE_LOAD: begin
                case (i_insn[14:12])
                    3'b000:  o_func = LSU_FUNC_LB;
                    3'b001:  o_func = LSU_FUNC_LH;
                    3'b100:  o_func = LSU_FUNC_LBU;
                    3'b101:  o_func = LSU_FUNC_LHU;
                    default: o_func = LSU_FUNC_LW;
                endcase
            end
            default: o_func = LSU_FUNC_LB;
        endcase
    end

    // The station only issues memory ops to this unit
    a_valid_opcode: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_valid |-> (i_opcode == OPCODE_LOAD) || (i_opcode == OPCODE_STORE)
    ) else $error("lsu_id: valid op with non load/store opcode");

endmodule

//--- hw/lsu_bus_pkg.sv
/* Wishbone-side types for the load/store unit. The bus is 32 bits wide with word
   addressing and classic, non-pipelined cycles. */

package lsu_bus_pkg;

    // Word address is byte address bits 31:2
    localparam int WB_ADR_WIDTH = 30;
    localparam int WB_SEL_WIDTH = 4;

    typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
    typedef logic [WB_SEL_WIDTH-1:0] wb_sel_t;

    // Control FSM states, one bus cycle per op
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_BUS  = 2'b01,
        ST_DONE = 2'b10
    } lsu_state_t;

endpackage

//--- hw/lsu_isa_pkg.sv
/* ISA-side types for the load/store unit. RV32 only, with no misaligned accesses
   and one in-order op queue of OP_QUEUE_DEPTH entries. */

package lsu_isa_pkg;

    // Datapath widths
    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int TAG_WIDTH    = 6;
    localparam int OPCODE_WIDTH = 7;

    // Op queue sizing
    localparam int OP_QUEUE_DEPTH     = 4;
    localparam int OP_QUEUE_PTR_WIDTH = $clog2(OP_QUEUE_DEPTH);

    typedef logic [DATA_WIDTH-1:0]   lsu_data_t;
    typedef logic [ADDR_WIDTH-1:0]   lsu_addr_t;
    typedef logic [TAG_WIDTH-1:0]    lsu_tag_t;
    typedef logic [OPCODE_WIDTH-1:0] lsu_opcode_t;

    typedef logic [OP_QUEUE_PTR_WIDTH-1:0] op_queue_ptr_t;
    typedef logic [OP_QUEUE_PTR_WIDTH:0]   op_queue_cnt_t;

    // Major opcodes handled by this unit
    localparam lsu_opcode_t OPCODE_LOAD  = 7'b0000011;
    localparam lsu_opcode_t OPCODE_STORE = 7'b0100011;

    // Load/store function after funct3 decode
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LBU = 3'b001,
        LSU_FUNC_LH  = 3'b010,
        LSU_FUNC_LHU = 3'b011,
        LSU_FUNC_LW  = 3'b100,
        LSU_FUNC_SB  = 3'b101,
        LSU_FUNC_SH  = 3'b110,
        LSU_FUNC_SW  = 3'b111
    } lsu_func_t;

endpackage
